// ==== Bender.yml ====
package:
  name: ball_drop

sources:
  - include_dirs:
      - source
    files:
      - source/ball_drop_pkg.sv
      - source/drop_ctrl.sv
      - source/aim_unit.sv
      - source/fall_unit.sv
      - source/slot_bank.sv
      - source/ball_drop_top.sv
      - target: test
        files:
          - dv/tb_ball_drop.sv

// ==== all.f ====
+incdir+source
source/ball_drop_pkg.sv
source/drop_ctrl.sv
source/aim_unit.sv
source/fall_unit.sv
source/slot_bank.sv
source/ball_drop_top.sv
dv/tb_ball_drop.sv

// ==== dv/tb_ball_drop.sv ====
`include "ball_drop_defs.svh"

module tb_ball_drop
    import ball_drop_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // one size letter per ball in drop order
    localparam string SCHEDULE = "MSMLSSMLSM";
    localparam int LAND_CYCLES = (`FLOOR_Y - `UP_BOUND + `FALL_STEP - 1) / `FALL_STEP;
    localparam int DROP_LATENCY = 1 + LAND_CYCLES + 1;
    localparam int MAX_CYCLES = `NUM_SLOTS * 60 + 2000;

    typedef struct packed {
        state_t                  state;
        idx_t                    idx;
        coord_t                  x;
        coord_t                  y;
        coord_t [`NUM_SLOTS-1:0] sx;
        coord_t [`NUM_SLOTS-1:0] sy;
        coord_t [`NUM_SLOTS-1:0] ssize;
    } model_t;

    logic   clk = 1'b0;
    logic   rst;
    logic   drop;
    logic   left;
    logic   right;
    coord_t slot_x    [`NUM_SLOTS];
    coord_t slot_y    [`NUM_SLOTS];
    coord_t slot_size [`NUM_SLOTS];
    idx_t   drop_idx;
    logic   finish;
    model_t model;
    int     cycle_count;

    ball_drop_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .drop      (drop),
        .left      (left),
        .right     (right),
        .slot_x    (slot_x),
        .slot_y    (slot_y),
        .slot_size (slot_size),
        .drop_idx  (drop_idx),
        .finish    (finish)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic coord_t ref_size(input int k);
        if (k >= `NUM_SLOTS) begin
            return coord_t'(`SIZE_EMPTY);
        end
        case (SCHEDULE[k])
            "S":     return coord_t'(`SIZE_S);
            "L":     return coord_t'(`SIZE_L);
            default: return coord_t'(`SIZE_M);
        endcase
    endfunction

    function automatic model_t reset_model();
        model_t m;
        m = '0;
        m.state = SELECT;
        m.x = coord_t'(`START_X);
        m.y = coord_t'(`UP_BOUND - `SIZE_M);
        return m;
    endfunction

    // one rising edge of the game rules
    function automatic model_t step_model(input model_t m, input logic d, input logic l,
                                          input logic r);
        model_t n;
        coord_t size;
        coord_t rest_y;
        n = m;
        size = ref_size(int'(m.idx));
        rest_y = coord_t'(`FLOOR_Y) - size;
        if (m.idx < `NUM_SLOTS) begin
            n.sx[m.idx] = m.x;
            n.sy[m.idx] = m.y;
            n.ssize[m.idx] = size;
        end
        case (m.state)
            SELECT: begin
                n.y = coord_t'(`UP_BOUND) - size;
                if (d && m.idx != `NUM_SLOTS) begin
                    n.state = FALLING;
                end
                if (!d && l && m.x > coord_t'(`LEFT_BOUND) + size) begin
                    n.x = m.x - 1;
                end else if (!d && !l && r && m.x < coord_t'(`RIGHT_BOUND) - size) begin
                    n.x = m.x + 1;
                end
            end
            FALLING: begin
                if (m.y == rest_y) begin
                    n.state = LANDED;
                end
                n.y = (m.y + `FALL_STEP > rest_y) ? rest_y : m.y + `FALL_STEP;
            end
            default: begin
                n.state = SELECT;
                n.x = coord_t'(`START_X);
                n.y = coord_t'(`UP_BOUND) - ref_size(int'(m.idx) + 1);
                if (m.idx != `NUM_SLOTS) begin
                    n.idx = m.idx + 1;
                end
            end
        endcase
        return n;
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic compare_outputs();
        check_value("drop_idx", int'(model.idx), int'(drop_idx));
        check_value("finish", int'(model.idx == `NUM_SLOTS), int'(finish));
        for (int k = 0; k < `NUM_SLOTS; k++) begin
            check_value($sformatf("slot_x[%0d]", k), int'(model.sx[k]), int'(slot_x[k]));
            check_value($sformatf("slot_y[%0d]", k), int'(model.sy[k]), int'(slot_y[k]));
            check_value($sformatf("slot_size[%0d]", k), int'(model.ssize[k]),
                        int'(slot_size[k]));
        end
    endtask

    // starts and ends on a falling edge
    task automatic drive_for(input logic d, input logic l, input logic r, input int n);
        drop = d;
        left = l;
        right = r;
        repeat (n) @(negedge clk);
    endtask

    task automatic aim_random(input int n);
        repeat (n) begin
            left = $urandom % 2;
            right = $urandom % 2;
            @(negedge clk);
        end
    endtask

    task automatic drop_ball();
        idx_t   start;
        coord_t prev_y;
        int     edges;
        start = drop_idx;
        prev_y = slot_y[start];
        drive_for(1'b1, 1'b0, 1'b0, 1);
        drop = 1'b0;
        edges = 1;
        while (drop_idx == start && edges <= 2 * DROP_LATENCY) begin
            if (slot_y[start] != prev_y) begin
                check_value("fall step y", int'(prev_y) + `FALL_STEP, int'(slot_y[start]));
            end
            prev_y = slot_y[start];
            @(negedge clk);
            edges++;
        end
        check_value("drop latency", DROP_LATENCY, edges - 1);
        check_value("landed y", `FLOOR_Y - int'(ref_size(int'(start))), int'(slot_y[start]));
        check_value("landed size", int'(ref_size(int'(start))), int'(slot_size[start]));
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $fatal(1);
    end

    // model steps on the rising edge and outputs are compared at the falling edge
    initial begin
        model = reset_model();
        forever begin
            @(posedge clk);
            if (rst) begin
                model = reset_model();
            end else begin
                model = step_model(model, drop, left, right);
            end
            @(negedge clk);
            compare_outputs();
        end
    end

    initial begin
        model_t frozen;
        void'($urandom(32'h6400a054));
        rst = 1'b1;
        drop = 1'b0;
        left = 1'b0;
        right = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        for (int k = 0; k < `NUM_SLOTS; k++) begin
            check_value("reset slot_size", `SIZE_EMPTY, int'(slot_size[k]));
        end
        check_value("reset drop_idx", 0, int'(drop_idx));
        check_value("reset finish", 0, int'(finish));
        @(negedge clk);
        check_value("first slot_x[0]", `START_X, int'(slot_x[0]));
        check_value("first slot_y[0]", `UP_BOUND - `SIZE_M, int'(slot_y[0]));
        drive_for(1'b0, 1'b1, 1'b0, 200);
        check_value("left bound", `LEFT_BOUND + `SIZE_M, int'(slot_x[0]));
        drive_for(1'b0, 1'b0, 1'b1, 200);
        check_value("right bound", `RIGHT_BOUND - `SIZE_M, int'(slot_x[0]));
        drive_for(1'b0, 1'b1, 1'b1, 200);
        check_value("left over right", `LEFT_BOUND + `SIZE_M, int'(slot_x[0]));
        drop_ball();
        for (int k = 1; k < `NUM_SLOTS; k++) begin
            aim_random(10 + $urandom % 71);
            drop_ball();
        end
        for (int k = 0; k < `NUM_SLOTS; k++) begin
            check_value($sformatf("final x %0d", k), int'(model.sx[k]), int'(slot_x[k]));
        end
        check_value("finish after last drop", 1, int'(finish));
        frozen = model;
        // inputs after the game must leave the board alone
        repeat (100) begin
            drop = $urandom % 2;
            left = $urandom % 2;
            right = $urandom % 2;
            @(negedge clk);
        end
        for (int k = 0; k < `NUM_SLOTS; k++) begin
            check_value("frozen x", int'(frozen.sx[k]), int'(slot_x[k]));
            check_value("frozen y", int'(frozen.sy[k]), int'(slot_y[k]));
            check_value("frozen size", int'(frozen.ssize[k]), int'(slot_size[k]));
        end
        check_value("frozen drop_idx", `NUM_SLOTS, int'(drop_idx));
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== source/aim_unit.sv ====
`include "ball_drop_defs.svh"

module aim_unit
    import ball_drop_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   drop,
    input  logic   left,
    input  logic   right,
    input  state_t state,
    input  coord_t ball_size,
    output coord_t x_pos
);

    localparam coord_t START_POS = coord_t'(`START_X);

    coord_t left_lim;
    coord_t right_lim;

    // the ball edge may touch the wall but not cross it
    assign left_lim  = coord_t'(`LEFT_BOUND) + ball_size;
    assign right_lim = coord_t'(`RIGHT_BOUND) - ball_size;

    always_ff @(posedge clk) begin
        if (rst) begin
            x_pos <= START_POS;
        end else begin
            case (state)
                SELECT: begin
                    // left wins, a release cycle freezes the aim
                    if (!drop && left) begin
                        if (x_pos > left_lim) begin
                            x_pos <= x_pos - coord_t'(1);
                        end
                    end else if (!drop && right) begin
                        if (x_pos < right_lim) begin
                            x_pos <= x_pos + coord_t'(1);
                        end
                    end
                end
                LANDED: begin
                    x_pos <= START_POS;
                end
                default: begin
                    x_pos <= x_pos;
                end
            endcase
        end
    end

endmodule

// ==== source/ball_drop_defs.svh ====
`ifndef BALL_DROP_DEFS_SVH
`define BALL_DROP_DEFS_SVH

// coordinate and size width
`define COORD_W 12

// balls per game and drop index width
`define NUM_SLOTS 10
`define IDX_W 4

// play area edges
`define LEFT_BOUND 100
`define RIGHT_BOUND 240
`define UP_BOUND 60
`define FLOOR_Y 240

// x of a freshly served ball
`define START_X 170

// pixels fallen per cycle
`define FALL_STEP 3

// ball radii, SIZE_EMPTY marks an unused slot
`define SIZE_EMPTY 0
`define SIZE_S 10
`define SIZE_M 15
`define SIZE_L 20

`endif

// ==== source/ball_drop_pkg.sv ====
`include "ball_drop_defs.svh"

package ball_drop_pkg;

    // game sequencer states
    typedef enum logic [1:0] {
        SELECT,
        FALLING,
        LANDED
    } state_t;

    // positions and radii share one width
    typedef logic [`COORD_W-1:0] coord_t;

    // drop counter, saturates at NUM_SLOTS
    typedef logic [`IDX_W-1:0] idx_t;

endpackage

// ==== source/ball_drop_top.sv ====
`include "ball_drop_defs.svh"

module ball_drop_top
    import ball_drop_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   drop,
    input  logic   left,
    input  logic   right,
    output coord_t slot_x    [`NUM_SLOTS],
    output coord_t slot_y    [`NUM_SLOTS],
    output coord_t slot_size [`NUM_SLOTS],
    output idx_t   drop_idx,
    output logic   finish
);

    state_t state;
    coord_t ball_size;
    coord_t next_size;
    coord_t x_pos;
    coord_t y_pos;
    logic   landed;

    drop_ctrl i_drop_ctrl (
        .clk       (clk),
        .rst       (rst),
        .drop      (drop),
        .landed    (landed),
        .state     (state),
        .drop_idx  (drop_idx),
        .ball_size (ball_size),
        .next_size (next_size),
        .finish    (finish)
    );

    aim_unit i_aim_unit (
        .clk       (clk),
        .rst       (rst),
        .drop      (drop),
        .left      (left),
        .right     (right),
        .state     (state),
        .ball_size (ball_size),
        .x_pos     (x_pos)
    );

    fall_unit i_fall_unit (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .ball_size (ball_size),
        .next_size (next_size),
        .y_pos     (y_pos),
        .landed    (landed)
    );

    slot_bank i_slot_bank (
        .clk       (clk),
        .rst       (rst),
        .drop_idx  (drop_idx),
        .x_pos     (x_pos),
        .y_pos     (y_pos),
        .ball_size (ball_size),
        .slot_x    (slot_x),
        .slot_y    (slot_y),
        .slot_size (slot_size)
    );

endmodule

// ==== source/drop_ctrl.sv ====
`include "ball_drop_defs.svh"

module drop_ctrl
    import ball_drop_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   drop,
    input  logic   landed,
    output state_t state,
    output idx_t   drop_idx,
    output coord_t ball_size,
    output coord_t next_size,
    output logic   finish
);

    localparam idx_t LAST_IDX = idx_t'(`NUM_SLOTS);

    state_t state_nxt;

    // size schedule M S M L S S M L S M, empty once the game is over
    function automatic coord_t size_of(input idx_t idx);
        case (idx)
            4'd0, 4'd2, 4'd6, 4'd9: size_of = coord_t'(`SIZE_M);
            4'd1, 4'd4, 4'd5, 4'd8: size_of = coord_t'(`SIZE_S);
            4'd3, 4'd7:             size_of = coord_t'(`SIZE_L);
            default:                size_of = coord_t'(`SIZE_EMPTY);
        endcase
    endfunction

    assign finish    = (drop_idx == LAST_IDX);
    assign ball_size = size_of(drop_idx);
    // size of the ball served after the current landing
    assign next_size = size_of(drop_idx + idx_t'(1));

    always_comb begin
        state_nxt = state;
        case (state)
            SELECT: begin
                // no new drops after the tenth ball
                if (drop && !finish) begin
                    state_nxt = FALLING;
                end
            end
            FALLING: begin
                if (landed) begin
                    state_nxt = LANDED;
                end
            end
            LANDED: begin
                state_nxt = SELECT;
            end
            default: begin
                state_nxt = SELECT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SELECT;
            drop_idx <= '0;
        end else begin
            state <= state_nxt;
            // count the finished drop as the FSM leaves LANDED
            if (state == LANDED && drop_idx != LAST_IDX) begin
                drop_idx <= drop_idx + idx_t'(1);
            end
        end
    end

endmodule

// ==== source/fall_unit.sv ====
`include "ball_drop_defs.svh"

module fall_unit
    import ball_drop_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  state_t state,
    input  coord_t ball_size,
    input  coord_t next_size,
    output coord_t y_pos,
    output logic   landed
);

    localparam coord_t STEP = coord_t'(`FALL_STEP);
    localparam coord_t TOP  = coord_t'(`UP_BOUND);

    coord_t floor_lim;
    coord_t top_lim;

    // ball centre rests one radius above the floor
    assign floor_lim = coord_t'(`FLOOR_Y) - ball_size;
    assign top_lim   = TOP - ball_size;
    assign landed    = (y_pos == floor_lim);

    always_ff @(posedge clk) begin
        if (rst) begin
            y_pos <= TOP - coord_t'(`SIZE_M);
        end else begin
            case (state)
                SELECT: begin
                    y_pos <= top_lim;
                end
                FALLING: begin
                    // last step is cut short at the floor
                    if (y_pos + STEP < floor_lim) begin
                        y_pos <= y_pos + STEP;
                    end else begin
                        y_pos <= floor_lim;
                    end
                end
                LANDED: begin
                    y_pos <= TOP - next_size;
                end
                default: begin
                    y_pos <= y_pos;
                end
            endcase
        end
    end

endmodule

// ==== source/slot_bank.sv ====
`include "ball_drop_defs.svh"

module slot_bank
    import ball_drop_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  idx_t   drop_idx,
    input  coord_t x_pos,
    input  coord_t y_pos,
    input  coord_t ball_size,
    output coord_t slot_x    [`NUM_SLOTS],
    output coord_t slot_y    [`NUM_SLOTS],
    output coord_t slot_size [`NUM_SLOTS]
);

    logic [`NUM_SLOTS-1:0] active;

    // one-hot slot select, all zero once drop_idx saturates
    always_comb begin
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            active[i] = (drop_idx == idx_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                slot_x[i]    <= '0;
                slot_y[i]    <= '0;
                slot_size[i] <= coord_t'(`SIZE_EMPTY);
            end
        end else begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                // active slot tracks the live ball, the rest keep their landing
                if (active[i]) begin
                    slot_x[i]    <= x_pos;
                    slot_y[i]    <= y_pos;
                    slot_size[i] <= ball_size;
                end
            end
        end
    end

endmodule
